// File: bench/ospfb_asserts.sv
`timescale 1ns/1ps
`default_nettype none

module ospfb_asserts import ospfb_pkg::*; #(
  parameter int FIFO_DEPTH=16,
  parameter int COUNT_WID=5
) (
  input wire logic                 clk,
  input wire logic                 rst_n,
  input wire logic                 fir_ready,
  input wire fir_beat_t            fir_out,
  input wire logic                 event_frame_started,
  input wire logic                 almost_full,
  input wire logic                 prog_full,
  input wire logic [COUNT_WID-1:0] count
);

  int fail_cnt = 0;  // read by the testbench at the end

  // stalled beat holds valid, data and frame
  a_beat_hold: assert property (@(posedge clk) disable iff (!rst_n)
    fir_out.valid && !fir_ready |=> $stable(fir_out))
    else begin
      $error("fir_out changed while fir_ready was low");
      fail_cnt++;
    end

  a_af_pf: assert property (@(posedge clk) disable iff (!rst_n)
    almost_full |-> prog_full)
    else begin
      $error("almost_full without prog_full");
      fail_cnt++;
    end

  a_count_max: assert property (@(posedge clk) disable iff (!rst_n)
    count <= COUNT_WID'(FIFO_DEPTH))
    else begin
      $error("fifo count above depth");
      fail_cnt++;
    end

  a_evt_valid: assert property (@(posedge clk) disable iff (!rst_n)
    event_frame_started |-> fir_out.valid)
    else begin
      $error("frame start pulse without a valid beat");
      fail_cnt++;
    end

endmodule

bind ospfb_ctr_top ospfb_asserts #(
  .FIFO_DEPTH(FIFO_DEPTH),
  .COUNT_WID(COUNT_WID)
) i_asserts (
  .clk(clk),
  .rst_n(rst_n),
  .fir_ready(fir_ready),
  .fir_out(fir_out),
  .event_frame_started(event_frame_started),
  .almost_full(almost_full),
  .prog_full(prog_full),
  .count(count)
);

`default_nettype wire

// File: bench/ospfb_tb.sv
`timescale 1ns/1ps
`default_nettype none

module ospfb_tb import ospfb_pkg::*; ();

  localparam int FFT_LEN    = 8;
  localparam int DEC_FAC    = 6;
  localparam int PTAPS      = 3;
  localparam int FIFO_DEPTH = 16;
  localparam int PROG_EMPTY = 4;
  localparam int PROG_FULL  = 12;
  localparam int SAMP       = 24;
  localparam int TAPS       = FFT_LEN*PTAPS;  // also the ramp period
  localparam int N_ROWS     = 6;

  localparam logic [1:0] RDY_HIGH = 2'd0;
  localparam logic [1:0] RDY_RAND = 2'd1;
  localparam logic [1:0] RDY_HOLD = 2'd2;  // low for a while and then high

  typedef struct packed {
    logic       en;
    logic [1:0] mode;
    logic [7:0] hold;    // cycles with fir_ready low
    logic [7:0] frames;  // frames to check after that
  } row_t;

  logic       clk;
  logic       rst_n;
  logic       en;
  logic       fir_ready;
  fir_beat_t  fir_out;
  logic       event_frame_started;
  logic       almost_empty;
  logic       almost_full;
  logic       prog_empty;
  logic       prog_full;
  logic [4:0] count;
  logic       vip_full;
  logic [4:0] rd_addr;
  pair_t      rd_data;

  row_t       rows [N_ROWS];
  int         ramp;         // next ramp value the source will send
  int         dl [TAPS];    // model delay line, dl[0] newest
  int         model_frame;
  fir_beat_t  exp_q [$];    // expected beats not yet transferred
  pair_t      cap_exp [SAMP];
  int         val_errs;
  int         proto_errs;
  int         tmo_errs;
  int         xfer_cnt;
  int         frames_done;
  int         beat_in_frame;
  int         ev_cnt;       // frame start pulses in the current frame
  int         max_count;
  logic       saw_pf;
  logic       saw_af;
  logic       aborted;
  logic [31:0] rng;

  ospfb_ctr_top #(
    .FFT_LEN(FFT_LEN),
    .DEC_FAC(DEC_FAC),
    .PTAPS(PTAPS),
    .FIFO_DEPTH(FIFO_DEPTH),
    .PROG_EMPTY_THRESH(PROG_EMPTY),
    .PROG_FULL_THRESH(PROG_FULL),
    .SAMP(SAMP)
  ) i_dut (
    .clk(clk),
    .rst_n(rst_n),
    .en(en),
    .fir_ready(fir_ready),
    .fir_out(fir_out),
    .event_frame_started(event_frame_started),
    .almost_empty(almost_empty),
    .almost_full(almost_full),
    .prog_empty(prog_empty),
    .prog_full(prog_full),
    .count(count),
    .vip_full(vip_full),
    .rd_addr(rd_addr),
    .rd_data(rd_data)
  );

  initial begin
    clk = 1'b0;
    forever #20 clk = ~clk;
  end

  function automatic logic [31:0] xorshift32(input logic [31:0] x);
    logic [31:0] y;
    y = x ^ (x << 13);
    y = y ^ (y >> 17);
    y = y ^ (y << 5);
    return y;
  endfunction

  task automatic compare_val(input string name, input logic [31:0] want, input logic [31:0] got);
    if (want !== got) begin
      val_errs++;
      $display("[FAIL] %0t %s expected %0h got %0h", $time, name, want, got);
    end
  endtask

  // shift in DEC_FAC ramp samples, queue one rotated frame of branch sums
  task automatic advance_frame();
    int k;
    int sum;
    fir_beat_t b;
    for (int i = 0; i < DEC_FAC; i++) begin
      for (int t = TAPS-1; t > 0; t--)
        dl[t] = dl[t-1];
      dl[0] = ramp;
      ramp  = (ramp + 1) % TAPS;
    end
    for (int j = 0; j < FFT_LEN; j++) begin
      k   = (j + model_frame*DEC_FAC) % FFT_LEN;
      sum = 0;
      for (int p = 0; p < PTAPS; p++)
        sum += int'(coeff_at(k + p*FFT_LEN)) * dl[k + p*FFT_LEN];
      b.valid   = 1'b1;
      b.data.re = 16'(sum);  // re and im carry the same ramp
      b.data.im = 16'(sum);
      b.frame   = 8'(model_frame);
      exp_q.push_back(b);
    end
    model_frame++;
  endtask

  // drive ready on the falling edge and check what the next rising edge takes
  task automatic step(input logic rdy);
    fir_beat_t e;
    @(negedge clk);
    fir_ready = rdy;
    compare_val("almost_full", count == FIFO_DEPTH-1, almost_full);
    compare_val("almost_empty", count == 1, almost_empty);
    compare_val("prog_full", count >= PROG_FULL, prog_full);
    compare_val("prog_empty", count <= PROG_EMPTY, prog_empty);
    compare_val("vip_full", xfer_cnt >= SAMP, vip_full);
    if (count > FIFO_DEPTH)
      compare_val("count", FIFO_DEPTH, count);
    if (count == PROG_FULL && prog_full)
      saw_pf = 1'b1;
    if (count == FIFO_DEPTH-1 && almost_full)
      saw_af = 1'b1;
    if (count > max_count)
      max_count = count;
    if (event_frame_started) begin
      ev_cnt++;
      if (!fir_out.valid || beat_in_frame != 0) begin
        proto_errs++;
        $display("frame start pulse at %0t is not on the first beat of a frame", $time);
      end
    end
    if (fir_out.valid && rdy) begin
      if (exp_q.size() == 0)
        advance_frame();
      e = exp_q.pop_front();
      compare_val("fir_out.data.re", e.data.re, fir_out.data.re);
      compare_val("fir_out.data.im", e.data.im, fir_out.data.im);
      compare_val("fir_out.frame", e.frame, fir_out.frame);
      if (xfer_cnt < SAMP)
        cap_exp[xfer_cnt] = e.data;  // what the capture memory should hold
      xfer_cnt++;
      beat_in_frame++;
      if (beat_in_frame == FFT_LEN) begin
        if (ev_cnt != 1) begin
          proto_errs++;
          $display("frame %0d had %0d frame start pulses instead of one", frames_done, ev_cnt);
        end
        ev_cnt        = 0;
        beat_in_frame = 0;
        frames_done++;
      end
    end
  endtask

  initial begin
    int   wait_cnt;
    int   limit;
    int   target;
    int   total;
    logic rdy;
    rst_n = 1'b0;
    en = 1'b0;
    fir_ready = 1'b0;
    rd_addr = '0;
    ramp = 0;
    model_frame = 0;
    val_errs = 0;
    proto_errs = 0;
    tmo_errs = 0;
    xfer_cnt = 0;
    frames_done = 0;
    beat_in_frame = 0;
    ev_cnt = 0;
    max_count = 0;
    saw_pf = 1'b0;
    saw_af = 1'b0;
    aborted = 1'b0;
    rng = 32'ha019;
    for (int i = 0; i < TAPS; i++)
      dl[i] = 0;
    rows[0] = '{1'b1, RDY_HOLD, 8'd40, 8'd3};  // fills from empty
    rows[1] = '{1'b1, RDY_HIGH, 8'd0,  8'd3};
    rows[2] = '{1'b1, RDY_RAND, 8'd0,  8'd6};
    rows[3] = '{1'b0, RDY_HIGH, 8'd0,  8'd2};  // source off so the fifo drains low
    rows[4] = '{1'b1, RDY_HOLD, 8'd40, 8'd2};
    rows[5] = '{1'b1, RDY_RAND, 8'd0,  8'd4};

    repeat (3) @(negedge clk);
    rst_n = 1'b1;
    compare_val("fir_out.valid", 0, fir_out.valid);
    compare_val("vip_full", 0, vip_full);
    compare_val("event_frame_started", 0, event_frame_started);
    compare_val("count", 0, count);
    compare_val("prog_empty", 1, prog_empty);

    for (int r = 0; r < N_ROWS && !aborted; r++) begin
      en = rows[r].en;
      if (rows[r].mode == RDY_HOLD) begin
        max_count = 0;
        saw_pf    = 1'b0;
        saw_af    = 1'b0;
        for (int c = 0; c < rows[r].hold; c++)
          step(1'b0);
        compare_val("count peak", FIFO_DEPTH, max_count);
        if (!saw_pf) begin
          proto_errs++;
          $display("row %0d never showed prog_full at count %0d", r, PROG_FULL);
        end
        if (!saw_af) begin
          proto_errs++;
          $display("row %0d never showed almost_full at count %0d", r, FIFO_DEPTH-1);
        end
      end
      target   = frames_done + rows[r].frames;
      limit    = rows[r].frames*100 + 200;
      wait_cnt = 0;
      while (frames_done < target && !aborted) begin
        if (rows[r].mode == RDY_RAND) begin
          rng = xorshift32(rng);
          rdy = rng[7];
        end else begin
          rdy = 1'b1;
        end
        step(rdy);
        wait_cnt++;
        if (wait_cnt > limit) begin
          tmo_errs++;
          aborted = 1'b1;
          $display("row %0d timed out after %0d cycles with %0d of %0d frames done",
                   r, wait_cnt, frames_done, target);
        end
      end
    end

    // readback of the capture memory
    en        = 1'b0;
    fir_ready = 1'b0;
    if (!aborted) begin
      compare_val("vip_full", 1, vip_full);
      for (int a = 0; a < SAMP; a++) begin
        @(negedge clk);
        rd_addr = 5'(a);
        @(negedge clk);
        compare_val($sformatf("rd_data[%0d]", a), cap_exp[a], rd_data);
      end
    end

    total = val_errs + proto_errs + tmo_errs + i_dut.i_asserts.fail_cnt;
    $display("errors: %0d value, %0d protocol, %0d timeout, %0d assertion",
             val_errs, proto_errs, tmo_errs, i_dut.i_asserts.fail_cnt);
    if (total == 0)
      $display("Testbench passed");
    else
      $display("Testbench failed");
    $finish;
  end

endmodule

`default_nettype wire

// File: files.f
rtl/ospfb_pkg.sv
rtl/src_ctr.sv
rtl/sample_fifo.sv
rtl/polyphase_fir.sv
rtl/frame_capture.sv
rtl/ospfb_ctr_top.sv
bench/ospfb_asserts.sv
bench/ospfb_tb.sv

// File: rtl/frame_capture.sv
`timescale 1ns/1ps
`default_nettype none

module frame_capture import ospfb_pkg::*; #(
  parameter int DEPTH=24,
  parameter int ADDR_W=5
) (
  input  wire logic              clk,
  input  wire logic              rst_n,
  input  fir_beat_t              beat,
  input  wire logic              ready,   // observed, never driven
  output logic                   full,
  input  wire logic [ADDR_W-1:0] rd_addr,
  output pair_t                  rd_data
);

  typedef logic [ADDR_W-1:0] addr_t;

  pair_t mem [DEPTH];
  addr_t wr_addr;
  logic  wr_en;

  assign wr_en = beat.valid & ready & ~full;  // stop once full

  always_ff @(posedge clk) begin
    if (wr_en)
      mem[wr_addr] <= beat.data;
    rd_data <= mem[rd_addr];  // one cycle read latency
  end

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      wr_addr <= '0;
      full    <= 1'b0;
    end else if (wr_en) begin
      if (wr_addr == addr_t'(DEPTH-1))
        full <= 1'b1;  // sticky until reset
      else
        wr_addr <= wr_addr + 1'b1;
    end
  end

endmodule

`default_nettype wire

// File: rtl/ospfb_ctr_top.sv
`timescale 1ns/1ps
`default_nettype none

module ospfb_ctr_top import ospfb_pkg::*; #(
  parameter int FFT_LEN=8,
  parameter int DEC_FAC=6,
  parameter int PTAPS=3,
  // fifo parameters
  parameter int FIFO_DEPTH=16,
  parameter int PROG_EMPTY_THRESH=4,
  parameter int PROG_FULL_THRESH=12,
  parameter int COUNT_WID=$clog2(FIFO_DEPTH+1),
  parameter int SAMP=24,                 // capture depth
  parameter int ADDR_W=$clog2(SAMP)
) (
  input  wire logic              clk,
  input  wire logic              rst_n,
  input  wire logic              en,
  input  wire logic              fir_ready,
  output fir_beat_t              fir_out,
  output logic                   event_frame_started,
  output logic                   almost_empty,
  output logic                   almost_full,
  output logic                   prog_empty,
  output logic                   prog_full,
  output logic [COUNT_WID-1:0]   count,
  output logic                   vip_full,
  input  wire logic [ADDR_W-1:0] rd_addr,
  output pair_t                  rd_data
);

  stream_t src_stream;   // ramp into the fifo
  logic    src_ready;
  stream_t fifo_stream;  // fifo head into the filter
  logic    fifo_ready;

  src_ctr #(
    .MAX_CNT(FFT_LEN*PTAPS)
  ) src_ctr_inst (
    .clk(clk),
    .rst_n(rst_n),
    .en(en),
    .m_stream(src_stream),
    .m_ready(src_ready)
  );

  sample_fifo #(
    .FIFO_DEPTH(FIFO_DEPTH),
    .PROG_EMPTY_THRESH(PROG_EMPTY_THRESH),
    .PROG_FULL_THRESH(PROG_FULL_THRESH),
    .COUNT_WID(COUNT_WID)
  ) fifo_inst (
    .clk(clk),
    .rst_n(rst_n),
    .s_stream(src_stream),
    .s_ready(src_ready),
    .m_stream(fifo_stream),
    .m_ready(fifo_ready),
    .almost_empty(almost_empty),
    .almost_full(almost_full),
    .prog_empty(prog_empty),
    .prog_full(prog_full),
    .count(count)
  );

  polyphase_fir #(
    .FFT_LEN(FFT_LEN),
    .DEC_FAC(DEC_FAC),
    .PTAPS(PTAPS)
  ) fir_inst (
    .clk(clk),
    .rst_n(rst_n),
    .s_stream(fifo_stream),
    .s_ready(fifo_ready),
    .m_beat(fir_out),
    .m_ready(fir_ready),
    .event_frame_started(event_frame_started)
  );

  // taps the filter output, same ready as the sink
  frame_capture #(
    .DEPTH(SAMP),
    .ADDR_W(ADDR_W)
  ) vip_inst (
    .clk(clk),
    .rst_n(rst_n),
    .beat(fir_out),
    .ready(fir_ready),
    .full(vip_full),
    .rd_addr(rd_addr),
    .rd_data(rd_data)
  );

endmodule

`default_nettype wire

// File: rtl/ospfb_pkg.sv
`default_nettype none

package ospfb_pkg;

  localparam int WIDTH=16;        // real sample width, fixed for the whole design
  localparam int COEFF_WID=16;
  localparam int FRAME_WID=8;     // frame tag carried with each fir beat

  typedef logic [WIDTH-1:0]     sample_t;
  typedef logic [COEFF_WID-1:0] coeff_t;
  typedef logic [FRAME_WID-1:0] frame_t;

  // complex pair, re in the upper half
  typedef struct packed {
    sample_t re;
    sample_t im;
  } pair_t;

  // plain valid/data stream, ready runs the other way
  typedef struct packed {
    logic  valid;
    pair_t data;
  } stream_t;

  // filter output beat with its frame number
  typedef struct packed {
    logic   valid;
    pair_t  data;
    frame_t frame;
  } fir_beat_t;

  // filter sequencer states
  typedef enum logic {
    fill,  // taking new samples into the delay line
    emit   // presenting one frame of branch sums
  } fir_state_t;

  // fixed taper standing in for a real prototype filter
  function automatic coeff_t coeff_at(input int n);
    return coeff_t'((n % 7) + 1);  // 1..7 repeating
  endfunction

endpackage

`default_nettype wire

// File: rtl/polyphase_fir.sv
`timescale 1ns/1ps
`default_nettype none

module polyphase_fir import ospfb_pkg::*; #(
  parameter int FFT_LEN=8,  // branches per frame
  parameter int DEC_FAC=6,  // new samples per frame
  parameter int PTAPS=3     // taps per branch
) (
  input  wire logic clk,
  input  wire logic rst_n,
  input  stream_t   s_stream,
  output logic      s_ready,
  output fir_beat_t m_beat,
  input  wire logic m_ready,
  output logic      event_frame_started
);

  localparam int TAPS  = FFT_LEN*PTAPS;
  localparam int IDX_W = (FFT_LEN > 1) ? $clog2(FFT_LEN) : 1;
  localparam int CNT_W = $clog2(DEC_FAC+1);
  localparam int STEP  = DEC_FAC % FFT_LEN;  // rotation advance per frame

  typedef logic [IDX_W-1:0] idx_t;
  typedef logic [CNT_W-1:0] cnt_t;

  fir_state_t state;
  pair_t      d [TAPS];   // d[0] newest
  cnt_t       samp_cnt;   // samples taken this frame
  idx_t       beat_idx;   // beat within the frame
  idx_t       rot;        // rotation offset of this frame
  idx_t       rot_next;
  idx_t       branch;     // branch shown on the current beat
  frame_t     frame_q;
  logic       frame_evt;
  logic       take;
  sample_t    acc_re;
  sample_t    acc_im;

  assign s_ready = (state == fill);  // no intake while emitting
  assign take    = s_ready & s_stream.valid;

  // rotated branch and next offset, both mod FFT_LEN
  always_comb begin
    int b;
    int r;
    b = int'(beat_idx) + int'(rot);
    if (b >= FFT_LEN)
      b = b - FFT_LEN;
    r = int'(rot) + STEP;
    if (r >= FFT_LEN)
      r = r - FFT_LEN;
    branch   = idx_t'(b);
    rot_next = idx_t'(r);
  end

  // branch multiply-accumulate, kept to 16 bits
  always_comb begin
    int tap;
    acc_re = '0;
    acc_im = '0;
    for (int p = 0; p < PTAPS; p++) begin
      tap    = int'(branch) + p*FFT_LEN;
      acc_re = acc_re + sample_t'(coeff_at(tap) * d[tap].re);
      acc_im = acc_im + sample_t'(coeff_at(tap) * d[tap].im);
    end
  end

  // delay line
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      for (int i = 0; i < TAPS; i++)
        d[i] <= '0;
    end else if (take) begin
      d[0] <= s_stream.data;
      for (int i = 1; i < TAPS; i++)
        d[i] <= d[i-1];  // shift toward the oldest tap
    end
  end

  // fill/emit sequencer
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      state     <= fill;
      samp_cnt  <= '0;
      beat_idx  <= '0;
      rot       <= '0;
      frame_q   <= '0;
      frame_evt <= 1'b0;
    end else begin
      frame_evt <= 1'b0;  // single-cycle pulse
      case (state)
        fill: begin
          if (take) begin
            if (samp_cnt == cnt_t'(DEC_FAC-1)) begin
              samp_cnt  <= '0;
              state     <= emit;
              frame_evt <= 1'b1;  // lines up with first valid beat
            end else begin
              samp_cnt <= samp_cnt + 1'b1;
            end
          end
        end
        emit: begin
          if (m_ready) begin
            if (beat_idx == idx_t'(FFT_LEN-1)) begin
              beat_idx <= '0;
              rot      <= rot_next;
              frame_q  <= frame_q + 1'b1;  // wraps at 256
              state    <= fill;
            end else begin
              beat_idx <= beat_idx + 1'b1;
            end
          end
        end
        default: state <= fill;
      endcase
    end
  end

  assign m_beat.valid        = (state == emit);
  assign m_beat.data.re      = acc_re;  // held while stalled, nothing moves
  assign m_beat.data.im      = acc_im;
  assign m_beat.frame        = frame_q;
  assign event_frame_started = frame_evt;

endmodule

`default_nettype wire

// File: rtl/sample_fifo.sv
`timescale 1ns/1ps
`default_nettype none

module sample_fifo import ospfb_pkg::*; #(
  parameter int FIFO_DEPTH=16,
  parameter int PROG_EMPTY_THRESH=4,
  parameter int PROG_FULL_THRESH=12,
  parameter int COUNT_WID=5
) (
  input  wire logic       clk,
  input  wire logic       rst_n,
  input  stream_t         s_stream,
  output logic            s_ready,
  output stream_t         m_stream,
  input  wire logic       m_ready,
  output logic            almost_empty,
  output logic            almost_full,
  output logic            prog_empty,
  output logic            prog_full,
  output logic [COUNT_WID-1:0] count
);

  localparam int PTR_W = (FIFO_DEPTH > 1) ? $clog2(FIFO_DEPTH) : 1;

  typedef logic [PTR_W-1:0]     ptr_t;
  typedef logic [COUNT_WID-1:0] lvl_t;

  pair_t mem [FIFO_DEPTH];  // payload only, no reset
  ptr_t  wr_ptr;
  ptr_t  rd_ptr;
  lvl_t  lvl;               // occupancy
  logic  wr_en;
  logic  rd_en;

  assign s_ready  = (lvl != lvl_t'(FIFO_DEPTH));
  assign wr_en    = s_stream.valid & s_ready;

  // fall-through: head word sits on the output
  assign m_stream.valid = (lvl != '0);
  assign m_stream.data  = mem[rd_ptr];
  assign rd_en          = m_stream.valid & m_ready;

  always_ff @(posedge clk) begin
    if (wr_en)
      mem[wr_ptr] <= s_stream.data;
  end

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      lvl    <= '0;
    end else begin
      if (wr_en)
        wr_ptr <= (wr_ptr == ptr_t'(FIFO_DEPTH-1)) ? '0 : wr_ptr + 1'b1;
      if (rd_en)
        rd_ptr <= (rd_ptr == ptr_t'(FIFO_DEPTH-1)) ? '0 : rd_ptr + 1'b1;
      case ({wr_en, rd_en})
        2'b10:   lvl <= lvl + 1'b1;
        2'b01:   lvl <= lvl - 1'b1;
        default: lvl <= lvl;  // both or neither
      endcase
    end
  end

  // level flags straight off the counter
  assign count        = lvl;
  assign almost_full  = (lvl == lvl_t'(FIFO_DEPTH-1));  // one write left
  assign almost_empty = (lvl == lvl_t'(1));             // one read left
  assign prog_full    = (lvl >= lvl_t'(PROG_FULL_THRESH));
  assign prog_empty   = (lvl <= lvl_t'(PROG_EMPTY_THRESH));

endmodule

`default_nettype wire

// File: rtl/src_ctr.sv
`timescale 1ns/1ps
`default_nettype none

module src_ctr import ospfb_pkg::*; #(
  parameter int MAX_CNT=24  // ramp wraps after MAX_CNT-1
) (
  input  wire logic clk,
  input  wire logic rst_n,
  input  wire logic en,
  output stream_t   m_stream,
  input  wire logic m_ready
);

  sample_t cnt;   // current ramp value
  logic    hold;  // beat offered but not yet taken
  logic    fire;

  assign m_stream.valid   = en | hold;  // keep offering a stalled beat after en drops
  assign m_stream.data.re = cnt;
  assign m_stream.data.im = cnt;        // same value on both paths
  assign fire             = m_stream.valid & m_ready;

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      cnt  <= '0;
      hold <= 1'b0;
    end else begin
      hold <= m_stream.valid & ~m_ready;
      if (fire) begin
        if (cnt == sample_t'(MAX_CNT-1))
          cnt <= '0;  // wrap
        else
          cnt <= cnt + 1'b1;
      end
    end
  end

endmodule

`default_nettype wire
